/* hw/max7219_pkg.sv */
package max7219_pkg;

    // ------------------------------
    // Field types
    // ------------------------------

    typedef logic [3:0]  reg_addr_t;
    typedef logic [7:0]  reg_data_t;
    // Header nibble, address nibble, data byte
    typedef logic [15:0] packet_t;
    typedef logic [3:0]  intensity_t;
    typedef logic [2:0]  row_idx_t;

    // Always zero on the MAX7219
    localparam logic [3:0] PKT_HDR = 4'h0;

    // ------------------------------
    // Register map
    // ------------------------------

    // Digit registers 1..8 hold pixel rows 0..7
    localparam reg_addr_t ADDR_DIGIT0     = 4'd1;
    localparam reg_addr_t ADDR_DECODE     = 4'd9;
    localparam reg_addr_t ADDR_INTENSITY  = 4'd10;
    localparam reg_addr_t ADDR_SCAN_LIMIT = 4'd11;
    localparam reg_addr_t ADDR_SHUTDOWN   = 4'd12;
    localparam reg_addr_t ADDR_TEST       = 4'd15;

    localparam reg_data_t DATA_SHUTDOWN    = 8'h00;
    localparam reg_data_t DATA_NORMAL      = 8'h01;
    localparam reg_data_t DATA_TEST_OFF    = 8'h00;
    localparam reg_data_t DATA_DECODE_NONE = 8'h00;
    // Scan digits 0 through 7
    localparam reg_data_t DATA_SCAN_ALL    = 8'h07;

    // Commands of one refresh, in issue order
    typedef enum logic [2:0] {
        CMD_SHUTDOWN    = 3'd0,
        CMD_NORMAL      = 3'd1,
        CMD_TEST_OFF    = 3'd2,
        CMD_DECODE_NONE = 3'd3,
        CMD_SCAN_LIMIT  = 3'd4,
        CMD_INTENSITY   = 3'd5,
        CMD_ROW         = 3'd6
    } cmd_t;

    function automatic packet_t make_packet(input reg_addr_t addr, input reg_data_t data);
        return {PKT_HDR, addr, data};
    endfunction

endpackage

/* hw/max7219_sequencer.sv */
`timescale 1ns/1ps

module max7219_sequencer #(
    parameter int PAUSE_CYCLES = 1000
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_busy,
    output logic                  o_cmd_stb,
    output max7219_pkg::cmd_t     o_cmd,
    output max7219_pkg::row_idx_t o_row
);

    import max7219_pkg::*;

    localparam int PAUSE_W = (PAUSE_CYCLES > 1) ? $clog2(PAUSE_CYCLES) : 1;

    typedef enum logic [1:0] {
        ISSUE      = 2'd0,
        WAIT_START = 2'd1,
        WAIT_DONE  = 2'd2,
        PAUSE      = 2'd3
    } state_t;

    state_t             r_state;
    logic [PAUSE_W-1:0] r_pause_cnt;
    logic               w_pause_done;
    logic               w_last_row;

    assign w_pause_done = (r_pause_cnt == PAUSE_W'(PAUSE_CYCLES - 1));
    assign w_last_row   = (o_cmd == CMD_ROW) && (o_row == row_idx_t'(7));

    // ------------------------------
    // Refresh FSM
    // ------------------------------
    // o_cmd and o_row always hold the command to be issued next

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_state     <= ISSUE;
            r_pause_cnt <= '0;
            o_cmd_stb   <= 1'b0;
            o_cmd       <= CMD_SHUTDOWN;
            o_row       <= '0;
        end else begin
            o_cmd_stb <= 1'b0;
            case (r_state)
                ISSUE: begin
                    o_cmd_stb <= 1'b1;
                    r_state   <= WAIT_START;
                end
                WAIT_START: begin
                    // Shifter picks the word up two cycles after the strobe
                    if (i_busy) begin
                        r_state <= WAIT_DONE;
                    end
                end
                WAIT_DONE: begin
                    if (!i_busy) begin
                        if (w_last_row) begin
                            o_cmd       <= CMD_SHUTDOWN;
                            o_row       <= '0;
                            r_pause_cnt <= '0;
                            r_state     <= PAUSE;
                        end else begin
                            r_state <= ISSUE;
                            case (o_cmd)
                                CMD_SHUTDOWN:    o_cmd <= CMD_NORMAL;
                                CMD_NORMAL:      o_cmd <= CMD_TEST_OFF;
                                CMD_TEST_OFF:    o_cmd <= CMD_DECODE_NONE;
                                CMD_DECODE_NONE: o_cmd <= CMD_SCAN_LIMIT;
                                CMD_SCAN_LIMIT:  o_cmd <= CMD_INTENSITY;
                                CMD_INTENSITY: begin
                                    o_cmd <= CMD_ROW;
                                    o_row <= '0;
                                end
                                CMD_ROW:         o_row <= o_row + 1'b1;
                                default:         o_cmd <= CMD_SHUTDOWN;
                            endcase
                        end
                    end
                end
                PAUSE: begin
                    // Line idle between refreshes
                    r_pause_cnt <= r_pause_cnt + 1'b1;
                    if (w_pause_done) begin
                        r_state <= ISSUE;
                    end
                end
                default: begin
                    r_state <= ISSUE;
                end
            endcase
        end
    end

endmodule

/* hw/max7219_frame_packer.sv */
`timescale 1ns/1ps

module max7219_frame_packer #(
    parameter int SEG_COLS = 4
) (
    input  logic                                    i_clk,
    input  logic                                    i_reset,
    input  logic [7:0][8*SEG_COLS-1:0]              i_frame,
    input  max7219_pkg::intensity_t [SEG_COLS-1:0]  i_intensity,
    input  logic                                    i_cmd_stb,
    input  max7219_pkg::cmd_t                       i_cmd,
    input  max7219_pkg::row_idx_t                   i_row,
    output logic                                    o_word_stb,
    output logic [16*SEG_COLS-1:0]                  o_word
);

    import max7219_pkg::*;

    localparam int WORD_W = 16 * SEG_COLS;

    // Snapshot taken at the start of each refresh
    logic [7:0][8*SEG_COLS-1:0]  r_frame;
    intensity_t [SEG_COLS-1:0]   r_intensity;
    logic [WORD_W-1:0]           w_word;

    // ------------------------------
    // Per-device packets
    // ------------------------------

    for (genvar d = 0; d < SEG_COLS; d++) begin : g_dev
        reg_data_t w_row_byte;
        packet_t   w_pkt;

        // Leftmost pixel of the device goes to data bit 7
        always_comb begin
            for (int j = 0; j < 8; j++) begin
                w_row_byte[7-j] = r_frame[i_row][8*d+j];
            end
        end

        always_comb begin
            case (i_cmd)
                CMD_SHUTDOWN:    w_pkt = make_packet(ADDR_SHUTDOWN, DATA_SHUTDOWN);
                CMD_NORMAL:      w_pkt = make_packet(ADDR_SHUTDOWN, DATA_NORMAL);
                CMD_TEST_OFF:    w_pkt = make_packet(ADDR_TEST, DATA_TEST_OFF);
                CMD_DECODE_NONE: w_pkt = make_packet(ADDR_DECODE, DATA_DECODE_NONE);
                CMD_SCAN_LIMIT:  w_pkt = make_packet(ADDR_SCAN_LIMIT, DATA_SCAN_ALL);
                CMD_INTENSITY:   w_pkt = make_packet(ADDR_INTENSITY, {4'h0, r_intensity[d]});
                CMD_ROW:         w_pkt = make_packet(ADDR_DIGIT0 + reg_addr_t'(i_row),
                                                     w_row_byte);
                default:         w_pkt = '0;
            endcase
        end

        // Device 0 is shifted last
        assign w_word[16*d +: 16] = w_pkt;
    end

    always_ff @(posedge i_clk) begin
        if (i_cmd_stb && (i_cmd == CMD_SHUTDOWN)) begin
            r_frame     <= i_frame;
            r_intensity <= i_intensity;
        end
        if (i_cmd_stb) begin
            o_word <= w_word;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_word_stb <= 1'b0;
        end else begin
            o_word_stb <= i_cmd_stb;
        end
    end

endmodule

/* hw/max7219_spi_shifter.sv */
`timescale 1ns/1ps

module max7219_spi_shifter #(
    parameter int SEG_COLS        = 4,
    parameter int SPI_HALF_CYCLES = 2
) (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_word_stb,
    input  logic [16*SEG_COLS-1:0] i_word,
    output logic                   o_busy,
    output logic                   o_spi_cs_n,
    output logic                   o_spi_clk,
    output logic                   o_spi_din
);

    localparam int WORD_W = 16 * SEG_COLS;
    localparam int HALF_W = (SPI_HALF_CYCLES > 1) ? $clog2(SPI_HALF_CYCLES) : 1;
    localparam int BIT_W  = $clog2(WORD_W);

    logic [WORD_W-1:0] r_shift;
    logic [HALF_W-1:0] r_half_cnt;
    logic [BIT_W-1:0]  r_bit_cnt;
    // Last high phase is over, chip-select rises next
    logic              r_last;
    logic              w_half_done;
    logic              w_fall;

    assign w_half_done = (r_half_cnt == HALF_W'(SPI_HALF_CYCLES - 1));
    // End of a high phase, sclk goes low
    assign w_fall      = o_busy && !r_last && w_half_done && o_spi_clk;

    always_ff @(posedge i_clk) begin
        if (!o_busy && i_word_stb) begin
            r_shift <= i_word;
        end else if (w_fall) begin
            r_shift <= r_shift << 1;
        end
    end

    // ------------------------------
    // Serial waveform
    // ------------------------------

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_busy     <= 1'b0;
            o_spi_cs_n <= 1'b1;
            o_spi_clk  <= 1'b0;
            o_spi_din  <= 1'b0;
            r_half_cnt <= '0;
            r_bit_cnt  <= '0;
            r_last     <= 1'b0;
        end else if (!o_busy) begin
            // New strobes are only looked at when idle
            if (i_word_stb) begin
                o_busy     <= 1'b1;
                o_spi_cs_n <= 1'b0;
                o_spi_din  <= i_word[WORD_W-1];
                r_half_cnt <= '0;
                r_bit_cnt  <= '0;
            end
        end else if (r_last) begin
            o_busy     <= 1'b0;
            o_spi_cs_n <= 1'b1;
            o_spi_din  <= 1'b0;
            r_last     <= 1'b0;
        end else if (w_half_done) begin
            r_half_cnt <= '0;
            if (!o_spi_clk) begin
                o_spi_clk <= 1'b1;
            end else begin
                o_spi_clk <= 1'b0;
                if (r_bit_cnt == BIT_W'(WORD_W - 1)) begin
                    r_last <= 1'b1;
                end else begin
                    r_bit_cnt <= r_bit_cnt + 1'b1;
                    o_spi_din <= r_shift[WORD_W-2];
                end
            end
        end else begin
            r_half_cnt <= r_half_cnt + 1'b1;
        end
    end

endmodule

/* hw/max7219_driver.sv */
`timescale 1ns/1ps

module max7219_driver #(
    parameter int SEG_COLS        = 4,
    parameter int SPI_HALF_CYCLES = 2,
    parameter int PAUSE_CYCLES    = 1000
) (
    input  logic                                    i_clk,
    input  logic                                    i_reset,
    // Pixel x of row r sits at i_frame[r][x]
    input  logic [7:0][8*SEG_COLS-1:0]              i_frame,
    input  max7219_pkg::intensity_t [SEG_COLS-1:0]  i_intensity,
    output logic                                    o_spi_cs_n,
    output logic                                    o_spi_clk,
    output logic                                    o_spi_din
);

    import max7219_pkg::*;

    localparam int WORD_W = 16 * SEG_COLS;

    logic              w_cmd_stb;
    cmd_t              w_cmd;
    row_idx_t          w_row;
    logic              w_word_stb;
    logic [WORD_W-1:0] w_word;
    logic              w_busy;

    max7219_sequencer #(
        .PAUSE_CYCLES (PAUSE_CYCLES)
    ) i_max7219_sequencer (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_busy    (w_busy),
        .o_cmd_stb (w_cmd_stb),
        .o_cmd     (w_cmd),
        .o_row     (w_row)
    );

    max7219_frame_packer #(
        .SEG_COLS (SEG_COLS)
    ) i_max7219_frame_packer (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_frame     (i_frame),
        .i_intensity (i_intensity),
        .i_cmd_stb   (w_cmd_stb),
        .i_cmd       (w_cmd),
        .i_row       (w_row),
        .o_word_stb  (w_word_stb),
        .o_word      (w_word)
    );

    max7219_spi_shifter #(
        .SEG_COLS        (SEG_COLS),
        .SPI_HALF_CYCLES (SPI_HALF_CYCLES)
    ) i_max7219_spi_shifter (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_word_stb (w_word_stb),
        .i_word     (w_word),
        .o_busy     (w_busy),
        .o_spi_cs_n (o_spi_cs_n),
        .o_spi_clk  (o_spi_clk),
        .o_spi_din  (o_spi_din)
    );

endmodule

/* sim/tb_max7219_driver.sv */
`timescale 1ns/1ps

module tb_max7219_driver;

    import max7219_pkg::*;

    localparam int SEG_COLS        = 3;
    localparam int SPI_HALF_CYCLES = 2;
    localparam int PAUSE_CYCLES    = 40;
    localparam int WORD_W          = 16 * SEG_COLS;
    localparam int ROW_W           = 8 * SEG_COLS;
    localparam int N_REFRESH       = 5;
    // One transfer plus a few handshake cycles, then the pause
    localparam int XFER_CYCLES     = 2 * SPI_HALF_CYCLES * WORD_W + 1;
    localparam int REFRESH_CYCLES  = 14 * (XFER_CYCLES + 8) + PAUSE_CYCLES;
    localparam int TIMEOUT_CYCLES  = 2 * N_REFRESH * REFRESH_CYCLES + 100;

    logic                            i_clk;
    logic                            i_reset;
    logic [7:0][ROW_W-1:0]           frame;
    intensity_t [SEG_COLS-1:0]       intensity;
    logic                            o_spi_cs_n;
    logic                            o_spi_clk;
    logic                            o_spi_din;

    int                cycle_cnt = 0;
    logic              prev_cs   = 1'b1;
    logic              prev_sclk = 1'b0;
    logic [WORD_W-1:0] shift_in  = '0;
    int                cur_edges = 0;
    int                cur_start = 0;
    logic [WORD_W-1:0] word_q[$];
    int                edge_q[$];
    int                start_q[$];
    int                end_q[$];

    max7219_driver #(
        .SEG_COLS        (SEG_COLS),
        .SPI_HALF_CYCLES (SPI_HALF_CYCLES),
        .PAUSE_CYCLES    (PAUSE_CYCLES)
    ) i_max7219_driver (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_frame     (frame),
        .i_intensity (intensity),
        .o_spi_cs_n  (o_spi_cs_n),
        .o_spi_clk   (o_spi_clk),
        .o_spi_din   (o_spi_din)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing", cycle_cnt);
            stop_on_failure();
        end
    end

    // ------------------------------
    // Serial line monitor
    // ------------------------------

    always @(negedge i_clk) begin
        if (!o_spi_cs_n && prev_cs) begin
            cur_start = cycle_cnt;
            cur_edges = 0;
            shift_in  = '0;
        end
        // Devices sample din on the rising sclk edge
        if (!o_spi_cs_n && o_spi_clk && !prev_sclk) begin
            shift_in  = {shift_in[WORD_W-2:0], o_spi_din};
            cur_edges = cur_edges + 1;
        end
        if (o_spi_cs_n && !prev_cs) begin
            word_q.push_back(shift_in);
            edge_q.push_back(cur_edges);
            start_q.push_back(cur_start);
            end_q.push_back(cycle_cnt);
        end
        prev_cs   = o_spi_cs_n;
        prev_sclk = o_spi_clk;
    end

    task automatic stop_on_failure();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped on first failure");
    endtask

    task automatic check_value(input string name, input logic [WORD_W-1:0] expected,
                               input logic [WORD_W-1:0] actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic apply_random_inputs();
        for (int r = 0; r < 8; r++) begin
            frame[r] = ROW_W'($urandom());
        end
        intensity = (4 * SEG_COLS)'($urandom());
    endtask

    // Register address and data of the five setup words
    function automatic logic [11:0] setup_addr_data(input int k);
        case (k)
            0:       return {4'd12, 8'h00};
            1:       return {4'd12, 8'h01};
            2:       return {4'd15, 8'h00};
            3:       return {4'd9, 8'h00};
            default: return {4'd11, 8'h07};
        endcase
    endfunction

    // Reference model for word k of a refresh
    function automatic logic [WORD_W-1:0] expected_word(input int k);
        logic [WORD_W-1:0] w;
        logic [3:0]        addr;
        logic [7:0]        data;
        int                r;
        w = '0;
        r = k - 6;
        for (int d = 0; d < SEG_COLS; d++) begin
            if (k < 5) begin
                {addr, data} = setup_addr_data(k);
            end else if (k == 5) begin
                addr = 4'd10;
                data = {4'h0, intensity[d]};
            end else begin
                addr = 4'(r + 1);
                data = '0;
                for (int x = 0; x < ROW_W; x++) begin
                    if (x / 8 == d) begin
                        data[7 - x % 8] = frame[r][x];
                    end
                end
            end
            w[16*d +: 16] = {4'h0, addr, data};
        end
        return w;
    endfunction

    initial begin : main_flow
        int                last_end;
        int                start_cyc;
        int                end_cyc;
        int                edges;
        logic [WORD_W-1:0] got;
        string             name;
        last_end = 0;
        i_reset  = 1'b1;
        void'($urandom(32'h44aa));
        apply_random_inputs();
        repeat (2) begin
            @(negedge i_clk);
            check_value("idle lines in reset", WORD_W'(3'b100),
                        WORD_W'({o_spi_cs_n, o_spi_clk, o_spi_din}));
        end
        i_reset = 1'b0;
        @(negedge i_clk);
        check_value("idle lines after reset", WORD_W'(3'b100),
                    WORD_W'({o_spi_cs_n, o_spi_clk, o_spi_din}));

        for (int r = 0; r < N_REFRESH; r++) begin
            for (int k = 0; k < 14; k++) begin
                while (word_q.size() == 0) begin
                    @(negedge i_clk);
                end
                got       = word_q.pop_front();
                edges     = edge_q.pop_front();
                start_cyc = start_q.pop_front();
                end_cyc   = end_q.pop_front();
                name      = $sformatf("refresh %0d word %0d", r, k + 1);
                check_value({name, " sclk edges"}, WORD_W'(WORD_W), WORD_W'(edges));
                check_value(name, expected_word(k), got);
                if (k == 0 && r > 0 && (start_cyc - last_end) < PAUSE_CYCLES) begin
                    $display("Pause before refresh %0d lasted only %0d cycles",
                             r, start_cyc - last_end);
                    stop_on_failure();
                end
                // New frame only while the line is idle
                if (k == 13) begin
                    last_end = end_cyc;
                    apply_random_inputs();
                end
            end
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

/* compile.f */
hw/max7219_pkg.sv
hw/max7219_sequencer.sv
hw/max7219_frame_packer.sv
hw/max7219_spi_shifter.sv
hw/max7219_driver.sv
sim/tb_max7219_driver.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the MAX7219 driver testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f compile.f --top-module tb_max7219_driver \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_max7219_driver > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"
